// File: include/board_lab_consts.svh
`ifndef BOARD_LAB_CONSTS_SVH
`define BOARD_LAB_CONSTS_SVH

// ****************************************
// board-wide constants.
// ****************************************

// clk cycles per tick, one second at 50 MHz.
`define BL_TICK_DIV 50000000

// largest value a bcd digit may hold.
`define BL_DIGIT_MAX 9

// active-low, every segment and the point dark.
`define BL_SEG_BLANK 8'hFF

`endif

// File: verilog/board_lab_pkg.sv
`include "board_lab_consts.svh"

package board_lab_pkg;

    typedef logic [3:0] nibble_t;
    typedef logic [3:0] digit_t;
    typedef logic [7:0] seg_t;
    typedef logic [2:0] code_t;
    typedef logic [7:0] line_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_NOT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_EQ
    } alu_op_t;

    // ****************************************
    // digit to segments, a in bit 0, point in bit 7.
    // ****************************************
    function automatic seg_t seg_pattern(input digit_t d);
        case (d)
            4'd0:    return 8'hC0;
            4'd1:    return 8'hF9;
            4'd2:    return 8'hA4;
            4'd3:    return 8'hB0;
            4'd4:    return 8'h99;
            4'd5:    return 8'h92;
            4'd6:    return 8'h82;
            4'd7:    return 8'hF8;
            4'd8:    return 8'h80;
            4'd9:    return 8'h90;
            default: return `BL_SEG_BLANK;
        endcase
    endfunction

endpackage

// File: verilog/tick_timer.sv
`include "board_lab_consts.svh"

module tick_timer #(
    parameter int unsigned tick_div = `BL_TICK_DIV
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int unsigned cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(tick_div - 1);

    logic [cnt_w-1:0] cnt_q;

    // counts down, reloads on zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= reload;
            tick  <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q <= reload;
            tick  <= 1'b1;
        end else begin
            cnt_q <= cnt_q - cnt_w'(1);
            tick  <= 1'b0;
        end
    end

    if (tick_div > 1) begin : g_tick_chk
        // single-cycle pulse.
        assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
            else $error("tick_timer: tick high two cycles in a row");
    end

endmodule

// File: verilog/bcd_counter.sv
`include "board_lab_consts.svh"

module bcd_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tick,
    input  logic                  count_en,
    output board_lab_pkg::digit_t tens,
    output board_lab_pkg::digit_t ones
);

    import board_lab_pkg::*;

    logic step;
    logic ones_at_max;
    logic tens_at_max;

    assign step        = tick & count_en;
    assign ones_at_max = (ones == digit_t'(`BL_DIGIT_MAX));
    assign tens_at_max = (tens == digit_t'(`BL_DIGIT_MAX));

    // ones carries into tens, 99 rolls over to 00.
    always_ff @(posedge clk) begin
        if (reset) begin
            tens <= '0;
            ones <= '0;
        end else if (step) begin
            if (ones_at_max) begin
                ones <= '0;
                if (tens_at_max) begin
                    tens <= '0;
                end else begin
                    tens <= tens + digit_t'(1);
                end
            end else begin
                ones <= ones + digit_t'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (tens <= digit_t'(`BL_DIGIT_MAX)) && (ones <= digit_t'(`BL_DIGIT_MAX)))
        else $error("bcd_counter: digit out of range %0d%0d", tens, ones);

endmodule

// File: verilog/seg_driver.sv
`include "board_lab_consts.svh"

module seg_driver (
    input  logic                  clk,
    input  logic                  reset,
    input  board_lab_pkg::digit_t tens,
    input  board_lab_pkg::digit_t ones,
    output board_lab_pkg::seg_t   seg0,
    output board_lab_pkg::seg_t   seg1
);

    import board_lab_pkg::*;

    seg_t seg0_next;
    seg_t seg1_next;

    // ****************************************
    // pattern lookup.
    // ****************************************

    // out-of-range digits come back blank.
    assign seg0_next = seg_pattern(ones);
    assign seg1_next = seg_pattern(tens);

    // ****************************************
    // output register.
    // ****************************************

    // seg0 is the ones digit, seg1 the tens.
    always_ff @(posedge clk) begin
        if (reset) begin
            seg0 <= `BL_SEG_BLANK;
            seg1 <= `BL_SEG_BLANK;
        end else begin
            seg0 <= seg0_next;
            seg1 <= seg1_next;
        end
    end

endmodule

// File: verilog/alu_4bit.sv
module alu_4bit (
    input  board_lab_pkg::alu_op_t alu_op,
    input  board_lab_pkg::nibble_t a,
    input  board_lab_pkg::nibble_t b,
    output board_lab_pkg::nibble_t result,
    output logic                   zero,
    output logic                   carry,
    output logic                   overflow
);

    import board_lab_pkg::*;

    logic    sub_sel;
    logic    arith_sel;
    nibble_t b_opnd;
    logic [4:0] sum5;
    logic    add_ovf;

    // ****************************************
    // shared adder, subtract is a + ~b + 1.
    // ****************************************
    assign sub_sel   = (alu_op == ALU_SUB);
    assign arith_sel = (alu_op == ALU_ADD) || (alu_op == ALU_SUB);
    assign b_opnd    = sub_sel ? ~b : b;
    assign sum5      = {1'b0, a} + {1'b0, b_opnd} + {4'b0000, sub_sel};

    // operands agree in sign, sum does not.
    assign add_ovf = (a[3] == b_opnd[3]) && (sum5[3] != a[3]);

    // ****************************************
    // result select.
    // ****************************************
    always_comb begin
        case (alu_op)
            ALU_ADD: result = sum5[3:0];
            ALU_SUB: result = sum5[3:0];
            ALU_NOT: result = ~a;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {3'b000, ($signed(a) < $signed(b))};
            ALU_EQ:  result = {3'b000, (a == b)};
            default: result = '0;
        endcase
    end

    // flags only meaningful for add and sub.
    assign carry    = arith_sel & sum5[4];
    assign overflow = arith_sel & add_ovf;
    assign zero     = (result == '0);

endmodule

// File: verilog/code_convert.sv
module code_convert (
    input  logic                 enc_en,
    input  board_lab_pkg::line_t enc_in,
    output board_lab_pkg::code_t enc_out,
    output logic                 enc_valid,
    input  logic                 dec_en,
    input  board_lab_pkg::code_t dec_in,
    output board_lab_pkg::line_t dec_out
);

    import board_lab_pkg::*;

    // ****************************************
    // 8-to-3 priority encoder.
    // ****************************************

    // scan upward so the highest set bit wins.
    always_comb begin
        enc_out   = '0;
        enc_valid = 1'b0;
        if (enc_en) begin
            for (int i = 0; i < 8; i++) begin
                if (enc_in[i]) begin
                    enc_out   = code_t'(i);
                    enc_valid = 1'b1;
                end
            end
        end
    end

    // ****************************************
    // 3-to-8 decoder.
    // ****************************************
    assign dec_out = dec_en ? (line_t'(1) << dec_in) : '0;

endmodule

// File: verilog/board_lab_top.sv
`include "board_lab_consts.svh"

module board_lab_top #(
    parameter int unsigned tick_div = `BL_TICK_DIV
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   count_en,
    input  board_lab_pkg::alu_op_t alu_op,
    input  board_lab_pkg::nibble_t alu_a,
    input  board_lab_pkg::nibble_t alu_b,
    input  logic                   enc_en,
    input  board_lab_pkg::line_t   enc_in,
    input  logic                   dec_en,
    input  board_lab_pkg::code_t   dec_in,
    output logic                   tick,
    output board_lab_pkg::digit_t  count_tens,
    output board_lab_pkg::digit_t  count_ones,
    output board_lab_pkg::seg_t    seg0,
    output board_lab_pkg::seg_t    seg1,
    output board_lab_pkg::nibble_t alu_result,
    output logic                   alu_zero,
    output logic                   alu_carry,
    output logic                   alu_overflow,
    output board_lab_pkg::code_t   enc_out,
    output logic                   enc_valid,
    output board_lab_pkg::line_t   dec_out
);

    // ****************************************
    // counter path, timer to display.
    // ****************************************
    tick_timer #(
        .tick_div (tick_div)
    ) tick_timer_inst (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    bcd_counter bcd_counter_inst (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .count_en (count_en),
        .tens     (count_tens),
        .ones     (count_ones)
    );

    seg_driver seg_driver_inst (
        .clk   (clk),
        .reset (reset),
        .tens  (count_tens),
        .ones  (count_ones),
        .seg0  (seg0),
        .seg1  (seg1)
    );

    // ****************************************
    // combinational blocks.
    // ****************************************
    alu_4bit alu_4bit_inst (
        .alu_op   (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .zero     (alu_zero),
        .carry    (alu_carry),
        .overflow (alu_overflow)
    );

    code_convert code_convert_inst (
        .enc_en    (enc_en),
        .enc_in    (enc_in),
        .enc_out   (enc_out),
        .enc_valid (enc_valid),
        .dec_en    (dec_en),
        .dec_in    (dec_in),
        .dec_out   (dec_out)
    );

endmodule

// File: verif/board_lab_tb.sv
`include "board_lab_consts.svh"

module board_lab_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import board_lab_pkg::*;

    localparam int tick_div    = 4;
    localparam int wrap_ticks  = 110;
    localparam int test_cycles = 4 + 100 + 150 + wrap_ticks * tick_div + 8 + 300 + 300;
    localparam int max_cycles  = 2 * test_cycles;

    logic    clk;
    logic    reset;
    logic    count_en;
    alu_op_t alu_op;
    nibble_t alu_a;
    nibble_t alu_b;
    logic    enc_en;
    line_t   enc_in;
    logic    dec_en;
    code_t   dec_in;
    logic    tick;
    digit_t  count_tens;
    digit_t  count_ones;
    seg_t    seg0;
    seg_t    seg1;
    nibble_t alu_result;
    logic    alu_zero;
    logic    alu_carry;
    logic    alu_overflow;
    code_t   enc_out;
    logic    enc_valid;
    line_t   dec_out;

    // counter path model.
    int    m_edges;
    logic  m_tick;
    int    m_value;
    seg_t  m_seg0;
    seg_t  m_seg1;
    int    cycle_count;
    string test_name;

    board_lab_top #(.tick_div(tick_div)) board_lab_top_inst (.*);

    always #50 clk = ~clk;

    // ****************************************
    // reference models.
    // ****************************************
    function automatic seg_t seg_ref(input int d);
        case (d)
            0:       return 8'hC0;
            1:       return 8'hF9;
            2:       return 8'hA4;
            3:       return 8'hB0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hF8;
            8:       return 8'h80;
            9:       return 8'h90;
            default: return `BL_SEG_BLANK;
        endcase
    endfunction

    function automatic code_t enc_ref(input line_t lines);
        code_t r;
        logic  found;
        r     = '0;
        found = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (!found && lines[i]) begin
                r     = code_t'(i);
                found = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic line_t dec_ref(input logic en, input code_t code);
        line_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = en && (int'(code) == i);
        end
        return r;
    endfunction

    // signed views taken from the 4-bit operands.
    task automatic alu_model(input alu_op_t op, input nibble_t a, input nibble_t b,
                             output nibble_t r, output logic c, output logic v);
        int ua;
        int ub;
        int sa;
        int sb;
        int s;
        ua = int'(a);
        ub = int'(b);
        sa = (ua > 7) ? ua - 16 : ua;
        sb = (ub > 7) ? ub - 16 : ub;
        c  = 1'b0;
        v  = 1'b0;
        case (op)
            ALU_ADD: begin
                s = ua + ub;
                c = s > 15;
                v = (sa + sb > 7) || (sa + sb < -8);
                r = nibble_t'(s);
            end
            ALU_SUB: begin
                s = ua + (15 - ub) + 1;
                c = s > 15;
                v = (sa - sb > 7) || (sa - sb < -8);
                r = nibble_t'(s);
            end
            ALU_NOT: r = nibble_t'(15 - ua);
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLT: r = (sa < sb) ? 4'd1 : 4'd0;
            ALU_EQ:  r = (ua == ub) ? 4'd1 : 4'd0;
            default: r = '0;
        endcase
    endtask

    always @(posedge clk) begin
        if (reset) begin
            m_edges <= 0;
            m_tick  <= 1'b0;
            m_value <= 0;
            m_seg0  <= `BL_SEG_BLANK;
            m_seg1  <= `BL_SEG_BLANK;
        end else begin
            m_edges <= m_edges + 1;
            m_tick  <= ((m_edges + 1) % tick_div) == 0;
            if (m_tick && count_en) begin
                m_value <= (m_value + 1) % 100;
            end
            m_seg0 <= seg_ref(m_value % 10);
            m_seg1 <= seg_ref(m_value / 10);
        end
    end

    // ****************************************
    // checks and run control.
    // ****************************************
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_digit(input string name, input digit_t exp, input digit_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_code(input string name, input code_t exp, input code_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // one clock, then the counter path against the model.
    task automatic next_cycle();
        @(negedge clk);
        check_bit($sformatf("%s tick", test_name), m_tick, tick);
        check_digit($sformatf("%s tens", test_name), digit_t'(m_value / 10), count_tens);
        check_digit($sformatf("%s ones", test_name), digit_t'(m_value % 10), count_ones);
        check_seg($sformatf("%s seg0", test_name), m_seg0, seg0);
        check_seg($sformatf("%s seg1", test_name), m_seg1, seg1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            abort_run($sformatf("timeout, the run hung after %0d cycles", cycle_count));
        end
    end

    initial begin
        int      stretch;
        int      pulses;
        int      ticks_seen;
        logic    prev_tick;
        logic    carry_due;
        digit_t  carry_tens;
        nibble_t exp_r;
        logic    exp_c;
        logic    exp_v;

        clk         = 1'b0;
        reset       = 1'b1;
        count_en    = 1'b0;
        alu_op      = ALU_ADD;
        alu_a       = '0;
        alu_b       = '0;
        enc_en      = 1'b0;
        enc_in      = '0;
        dec_en      = 1'b0;
        dec_in      = '0;
        cycle_count = 0;
        carry_tens  = '0;
        void'($urandom(32'h9a9d547a));

        // reset, blank display then zeros.
        test_name = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("reset tick", 1'b0, tick);
        check_digit("reset tens", 4'd0, count_tens);
        check_digit("reset ones", 4'd0, count_ones);
        check_seg("reset seg0", `BL_SEG_BLANK, seg0);
        check_seg("reset seg1", `BL_SEG_BLANK, seg1);
        reset = 1'b0;
        next_cycle();
        check_seg("reset seg0 zero", seg_ref(0), seg0);
        check_seg("reset seg1 zero", seg_ref(0), seg1);

        test_name = "tick_period";
        pulses    = 0;
        prev_tick = 1'b0;
        repeat (100) begin
            next_cycle();
            check_bit("tick_period double", 1'b0, prev_tick & tick);
            prev_tick = tick;
            if (tick) begin
                pulses++;
            end
        end
        if (pulses != 100 / tick_div) begin
            abort_run("tick_period: tick did not pulse once every four cycles");
        end

        // enable held for random stretches.
        test_name = "counting";
        stretch   = 0;
        repeat (150) begin
            if (stretch == 0) begin
                count_en = 1'($urandom_range(0, 1));
                stretch  = int'($urandom_range(5, 20));
            end
            stretch--;
            next_cycle();
        end

        test_name  = "wrap";
        count_en   = 1'b1;
        ticks_seen = 0;
        carry_due  = 1'b0;
        while (ticks_seen < wrap_ticks || carry_due) begin
            next_cycle();
            if (carry_due) begin
                check_digit("wrap carry tens", carry_tens, count_tens);
                check_digit("wrap carry ones", 4'd0, count_ones);
            end
            carry_due  = m_tick && (m_value % 10 == 9);
            carry_tens = digit_t'(((m_value + 1) % 100) / 10);
            if (m_tick) begin
                ticks_seen++;
            end
        end

        // ****************************************
        // combinational blocks.
        // ****************************************
        test_name = "alu";
        repeat (300) begin
            alu_op = alu_op_t'(3'($urandom_range(0, 7)));
            alu_a  = nibble_t'($urandom());
            alu_b  = nibble_t'($urandom());
            next_cycle();
            alu_model(alu_op, alu_a, alu_b, exp_r, exp_c, exp_v);
            check_nibble($sformatf("alu %s result", alu_op.name()), exp_r, alu_result);
            check_bit($sformatf("alu %s zero", alu_op.name()), exp_r == 4'd0, alu_zero);
            check_bit($sformatf("alu %s carry", alu_op.name()), exp_c, alu_carry);
            check_bit($sformatf("alu %s overflow", alu_op.name()), exp_v, alu_overflow);
        end

        test_name = "code_convert";
        repeat (300) begin
            enc_en = 1'($urandom_range(0, 1));
            enc_in = ($urandom_range(0, 3) == 0) ? 8'h00 : line_t'($urandom());
            dec_en = 1'($urandom_range(0, 1));
            dec_in = code_t'($urandom());
            next_cycle();
            check_code("code_convert enc_out", enc_en ? enc_ref(enc_in) : 3'd0, enc_out);
            check_bit("code_convert enc_valid", enc_en && (enc_in != 8'h00), enc_valid);
            check_line("code_convert dec_out", dec_ref(dec_en, dec_in), dec_out);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: board_lab.f
+incdir+include
verilog/board_lab_pkg.sv
verilog/tick_timer.sv
verilog/bcd_counter.sv
verilog/seg_driver.sv
verilog/alu_4bit.sv
verilog/code_convert.sv
verilog/board_lab_top.sv
verif/board_lab_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build board_lab with Verilator and run the testbench.

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module board_lab_tb -Mdir "$obj_dir" -f board_lab.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$obj_dir/Vboard_lab_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "SOME TESTS FAILED" "$log_file"; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
